/* vlog.f */
aes_key_pkg.sv
aes_sbox_lut.sv
aes_rcon_gen.sv
aes_key_irregular.sv
aes_key_regular.sv
aes_key_hs_ctrl.sv
aes_key_expand.sv
tb_clk_gen.sv
tb_aes_key_expand.sv

/* tb_aes_key_expand.sv */
// Testbench of the AES round-key update unit
// LCG key generator and FIPS-197 key schedule model
// Four-phase request driver with back-pressure and timeout loops
// AES-128/256 sequences in both directions, AES-256 round 0, reset state

`timescale 1ns/100ps
`default_nettype none

module tb_aes_key_expand;

  localparam int NumKeys   = 4;
  localparam int WaitLimit = 50;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  logic                  clear;
  aes_key_pkg::ciph_op_e op;
  aes_key_pkg::key_len_e key_len;
  aes_key_pkg::round_t   round;
  aes_key_pkg::key_t     key_in;
  logic                  ack;
  aes_key_pkg::key_t     key_out;

  logic [31:0] rng_state;
  logic [7:0]  sbox_tab [256];
  // Model schedule words, AES-128 uses only the first 44
  logic [31:0] w [60];
  int          n_tests;
  int          n_failed;
  int          n_errors;
  logic        hung;

  tb_clk_gen u_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  aes_key_expand DUT (
    .clk_i     ( clk     ),
    .rst_ni    ( rst_n   ),
    .req_i     ( req     ),
    .clear_i   ( clear   ),
    .op_i      ( op      ),
    .key_len_i ( key_len ),
    .round_i   ( round   ),
    .key_i     ( key_in  ),
    .ack_o     ( ack     ),
    .key_o     ( key_out )
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Classic 32-bit LCG step
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [7:0] gf_mul(logic [7:0] a, logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = '0;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

  // S-box from field inverse plus affine map
  task automatic build_sbox();
    logic [7:0] inv;
    for (int x = 0; x < 256; x++) begin
      // x^254 is the inverse and keeps 0 at 0
      inv = 8'h01;
      for (int e = 0; e < 254; e++) begin
        inv = gf_mul(inv, x[7:0]);
      end
      sbox_tab[x] = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                  ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    end
  endtask

  function automatic logic [31:0] sub_word(logic [31:0] in);
    logic [31:0] out;
    for (int b = 0; b < 4; b++) begin
      out[8*b +: 8] = sbox_tab[in[8*b +: 8]];
    end
    return out;
  endfunction

  // Random cipher key then full schedule, byte 0 of a word in bits 7:0
  task automatic new_schedule(input int nk);
    logic [31:0] t;
    logic [7:0]  rc;
    int          total;
    total = (nk == 4) ? 44 : 60;
    rc    = 8'h01;
    for (int i = 0; i < nk; i++) begin
      w[i] = next_rand();
    end
    for (int i = nk; i < total; i++) begin
      t = w[i-1];
      if (i % nk == 0) begin
        // RotWord then SubWord then Rcon
        t = sub_word({t[7:0], t[31:8]});
        t[7:0] = t[7:0] ^ rc;
        rc = gf_mul(rc, 8'h02);
      end else if (nk == 8 && i % 8 == 4) begin
        t = sub_word(t);
      end
      w[i] = w[i-nk] ^ t;
    end
  endtask

  // Words 3:0 from w[lo..], words 7:4 from w[hi..]
  function automatic aes_key_pkg::key_t make_key(int lo, int hi);
    aes_key_pkg::key_t k;
    for (int i = 0; i < 4; i++) begin
      k[i].word   = w[lo+i];
      k[i+4].word = w[hi+i];
    end
    return k;
  endfunction

  // Register contents after step r
  function automatic aes_key_pkg::key_t expected_key(aes_key_pkg::ciph_op_e op_v,
      aes_key_pkg::key_len_e len_v, int r);
    if (len_v == aes_key_pkg::AES_128) begin
      if (op_v == aes_key_pkg::CIPH_FWD) begin
        return make_key(4*r, 4*r-4);
      end
      return make_key(40-4*r, 44-4*r);
    end
    if (op_v == aes_key_pkg::CIPH_FWD) begin
      return make_key(4*r, 4*r+4);
    end
    return make_key(52-4*r, 56-4*r);
  endfunction

  ////////////////////
  // Driver
  ////////////////////

  // Call right after a falling edge
  task automatic wait_ack(input logic level, input string name);
    int cnt;
    cnt = 0;
    while (ack !== level && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    assert (ack === level) else begin
      $display("%s: ack_o did not go to %b within %0d cycles", name, level, WaitLimit);
      hung = 1'b1;
      n_errors++;
    end
  endtask

  task automatic clear_rcon(input aes_key_pkg::ciph_op_e op_v,
      input aes_key_pkg::key_len_e len_v);
    @(posedge clk);
    op      <= op_v;
    key_len <= len_v;
    clear   <= 1'b1;
    @(posedge clk);
    clear   <= 1'b0;
  endtask

  // Full four-phase cycle, req_i held for hold extra cycles after ack
  task automatic run_request(input string name, input int step,
      input aes_key_pkg::ciph_op_e op_v, input aes_key_pkg::key_len_e len_v,
      input aes_key_pkg::round_t rnd, input aes_key_pkg::key_t kin,
      input aes_key_pkg::key_t expected, input int hold);
    aes_key_pkg::key_t held;
    if (hung) begin
      return;
    end
    @(posedge clk);
    op      <= op_v;
    key_len <= len_v;
    round   <= rnd;
    key_in  <= kin;
    req     <= 1'b1;
    @(negedge clk);
    wait_ack(1'b1, name);
    if (hung) begin
      return;
    end
    assert (key_out === expected) else begin
      $display("Mismatch %s step %0d: expected %h, actual %h", name, step, expected, key_out);
      n_errors++;
    end
    held = key_out;
    // Back-pressure
    repeat (hold) begin
      @(negedge clk);
      assert (ack === 1'b1 && key_out === held) else begin
        $display("%s step %0d: ack_o dropped or key_o moved while req_i was high", name, step);
        n_errors++;
      end
    end
    @(posedge clk);
    req <= 1'b0;
    // req_i low is sampled on the next edge only
    @(negedge clk);
    assert (ack === 1'b1) else begin
      $display("%s step %0d: ack_o fell before req_i was sampled low", name, step);
      n_errors++;
    end
    wait_ack(1'b0, name);
  endtask

  // Feeds each result back as the next input
  task automatic run_schedule(input string name, input aes_key_pkg::ciph_op_e op_v,
      input aes_key_pkg::key_len_e len_v, input int nsteps, input aes_key_pkg::key_t start);
    aes_key_pkg::key_t cur;
    clear_rcon(op_v, len_v);
    cur = start;
    for (int r = 1; r <= nsteps; r++) begin
      run_request(name, r, op_v, len_v, aes_key_pkg::round_t'(r), cur,
                  expected_key(op_v, len_v, r), int'(next_rand() >> 30));
      cur = key_out;
    end
  endtask

  // Round 0 swaps halves and leaves Rcon for round 1
  task automatic run_round0(input string name);
    clear_rcon(aes_key_pkg::CIPH_FWD, aes_key_pkg::AES_256);
    run_request(name, 0, aes_key_pkg::CIPH_FWD, aes_key_pkg::AES_256, 4'd0,
                make_key(4, 0), make_key(0, 4), int'(next_rand() >> 29));
    run_request(name, 1, aes_key_pkg::CIPH_FWD, aes_key_pkg::AES_256, 4'd1,
                key_out, make_key(4, 8), int'(next_rand() >> 29));
  endtask

  task automatic end_test(input string name, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("%s: pass", name);
    end else begin
      n_failed++;
      $display("%s: FAIL, %0d errors", name, n_errors - errs_before);
    end
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin : main
    int    errs_before;
    int    cnt;
    rng_state = 32'hf1b9;
    n_tests   = 0;
    n_failed  = 0;
    n_errors  = 0;
    hung      = 1'b0;
    req       = 1'b0;
    clear     = 1'b0;
    op        = aes_key_pkg::CIPH_FWD;
    key_len   = aes_key_pkg::AES_128;
    round     = '0;
    key_in    = '0;
    build_sbox();

    cnt = 0;
    while (rst_n !== 1'b1 && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    assert (rst_n === 1'b1) else begin
      $display("Reset was never released");
      hung = 1'b1;
      n_errors++;
    end

    // Nothing requested yet
    errs_before = n_errors;
    @(negedge clk);
    assert (ack === 1'b0) else begin
      $display("Mismatch reset_state ack_o: expected 0, actual %b", ack);
      n_errors++;
    end
    assert (key_out === '0) else begin
      $display("Mismatch reset_state key_o: expected %h, actual %h", 256'h0, key_out);
      n_errors++;
    end
    end_test("reset_state", errs_before);

    for (int k = 0; k < NumKeys; k++) begin
      new_schedule(4);
      errs_before = n_errors;
      run_schedule($sformatf("aes128_fwd_key%0d", k), aes_key_pkg::CIPH_FWD,
                   aes_key_pkg::AES_128, 10, make_key(0, 0));
      end_test($sformatf("aes128_fwd_key%0d", k), errs_before);
      errs_before = n_errors;
      run_schedule($sformatf("aes128_inv_key%0d", k), aes_key_pkg::CIPH_INV,
                   aes_key_pkg::AES_128, 10, make_key(40, 40));
      end_test($sformatf("aes128_inv_key%0d", k), errs_before);

      new_schedule(8);
      errs_before = n_errors;
      run_schedule($sformatf("aes256_fwd_key%0d", k), aes_key_pkg::CIPH_FWD,
                   aes_key_pkg::AES_256, 13, make_key(0, 4));
      end_test($sformatf("aes256_fwd_key%0d", k), errs_before);
      errs_before = n_errors;
      run_schedule($sformatf("aes256_inv_key%0d", k), aes_key_pkg::CIPH_INV,
                   aes_key_pkg::AES_256, 13, make_key(52, 56));
      end_test($sformatf("aes256_inv_key%0d", k), errs_before);
      errs_before = n_errors;
      run_round0($sformatf("aes256_round0_key%0d", k));
      end_test($sformatf("aes256_round0_key%0d", k), errs_before);
    end

    $display("%0d tests run, %0d failed, %0d errors", n_tests, n_failed, n_errors);
    if (n_errors == 0 && !hung) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Testbench clock and reset source
// 4 ns clock, active-low reset held for the first 16 cycles

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod  = 2;
  localparam int ResetCycles = 16;

  initial begin : clk_loop
    clk_o = 1'b0;
    forever begin
      #HalfPeriod clk_o = ~clk_o;
    end
  end

  // Release on a falling edge, away from the sampling edge
  initial begin : rst_seq
    rst_no = 1'b0;
    repeat (ResetCycles) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* aes_key_expand.sv */
// Round-key update unit, top level
// Wires Rcon generator, irregular and regular datapath and handshake control

`timescale 1ns/100ps
`default_nettype none

module aes_key_expand (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  clear_i,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  aes_key_pkg::round_t   round_i,
  input  aes_key_pkg::key_t     key_i,
  output logic                  ack_o,
  output aes_key_pkg::key_t     key_o
);

  logic [7:0]             rcon;
  logic                   use_rcon;
  logic                   advance;
  aes_key_pkg::key_word_u irregular;
  aes_key_pkg::key_t      next_key;

  aes_rcon_gen u_rcon_gen (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .clear_i    ( clear_i   ),
    .advance_i  ( advance   ),
    .op_i       ( op_i      ),
    .key_len_i  ( key_len_i ),
    .round_i    ( round_i   ),
    .rcon_o     ( rcon      ),
    .use_rcon_o ( use_rcon  )
  );

  // Combinational datapath from key_i to next_key
  aes_key_irregular u_irregular (
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .key_i       ( key_i     ),
    .use_rcon_i  ( use_rcon  ),
    .rcon_i      ( rcon      ),
    .irregular_o ( irregular )
  );

  aes_key_regular u_regular (
    .op_i        ( op_i      ),
    .key_len_i   ( key_len_i ),
    .round_i     ( round_i   ),
    .key_i       ( key_i     ),
    .irregular_i ( irregular ),
    .next_key_o  ( next_key  )
  );

  aes_key_hs_ctrl u_hs_ctrl (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .req_i      ( req_i    ),
    .next_key_i ( next_key ),
    .ack_o      ( ack_o    ),
    .advance_o  ( advance  ),
    .key_o      ( key_o    )
  );

endmodule

`default_nettype wire

/* aes_key_hs_ctrl.sv */
// Four-phase req/ack sequencer of the key expansion
// Output key register and the Rcon advance strobe

`timescale 1ns/100ps
`default_nettype none

module aes_key_hs_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  aes_key_pkg::key_t next_key_i,
  output logic              ack_o,
  output logic              advance_o,
  output aes_key_pkg::key_t key_o
);

  typedef enum logic {
    HsIdle = 1'b0,
    HsAck  = 1'b1
  } hs_state_e;

  hs_state_e         state_d;
  hs_state_e         state_q;
  logic              req_q;
  aes_key_pkg::key_t key_q;

  // Sampled request, gives the one-cycle delay on both ack edges
  always_ff @(posedge clk_i or negedge rst_ni) begin : req_reg
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else begin
      req_q <= req_i;
    end
  end

  ////////////////////
  // Sequencer
  ////////////////////

  always_comb begin : hs_fsm
    state_d = state_q;
    unique case (state_q)
      HsIdle:  if (req_q) state_d = HsAck;
      HsAck:   if (!req_q) state_d = HsIdle;
      default: state_d = HsIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
    if (!rst_ni) begin
      state_q <= HsIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // High in the cycle that ends with ack rising
  assign advance_o = (state_q == HsIdle) & req_q;

  // Result is captured together with the Rcon step
  always_ff @(posedge clk_i or negedge rst_ni) begin : key_reg
    if (!rst_ni) begin
      key_q <= '0;
    end else if (advance_o) begin
      key_q <= next_key_i;
    end
  end

  assign ack_o = (state_q == HsAck);
  assign key_o = key_q;

  ack_rise_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_o) |-> req_i);

  // Back-pressure keeps the result frozen
  key_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o ##1 ack_o |-> $stable(key_o));

endmodule

`default_nettype wire

/* aes_key_regular.sv */
// Regular part of the key expansion
// XOR word chains and half shifts for AES-128 and AES-256, both directions
// AES-256 round 0 only swaps the halves

`timescale 1ns/100ps
`default_nettype none

module aes_key_regular (
  input  aes_key_pkg::ciph_op_e  op_i,
  input  aes_key_pkg::key_len_e  key_len_i,
  input  aes_key_pkg::round_t    round_i,
  input  aes_key_pkg::key_t      key_i,
  input  aes_key_pkg::key_word_u irregular_i,
  output aes_key_pkg::key_t      next_key_o
);

  always_comb begin : drive_regular
    next_key_o = key_i;

    if (key_len_i == aes_key_pkg::AES_128) begin
      ////////////////////
      // AES-128
      ////////////////////
      // Upper half is unused, it just keeps the previous round key
      next_key_o[7:4] = key_i[3:0];
      next_key_o[0].word = irregular_i.word ^ key_i[0].word;
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        // Each word chains from the new word below it
        for (int i = 1; i < 4; i++) begin
          next_key_o[i].word = next_key_o[i-1].word ^ key_i[i].word;
        end
      end else begin
        // Going back, neighbouring old words give the earlier word
        for (int i = 1; i < 4; i++) begin
          next_key_o[i].word = key_i[i-1].word ^ key_i[i].word;
        end
      end
    end else if (round_i == '0) begin
      ////////////////////
      // AES-256
      ////////////////////
      // Round 0 has no computation, halves trade places
      next_key_o = {key_i[3:0], key_i[7:4]};
    end else if (op_i == aes_key_pkg::CIPH_FWD) begin
      // Old upper half drops down
      next_key_o[3:0] = key_i[7:4];
      // New upper half grows from the irregular word
      next_key_o[4].word = irregular_i.word ^ key_i[0].word;
      for (int i = 1; i < 4; i++) begin
        next_key_o[i+4].word = next_key_o[i+3].word ^ key_i[i].word;
      end
    end else begin
      // Old lower half moves up
      next_key_o[7:4] = key_i[3:0];
      // New lower half from the old upper half
      next_key_o[0].word = irregular_i.word ^ key_i[4].word;
      for (int i = 0; i < 3; i++) begin
        next_key_o[i+1].word = key_i[4+i].word ^ key_i[5+i].word;
      end
    end
  end

endmodule

`default_nettype wire

/* aes_key_irregular.sv */
// Irregular part of the key expansion
// Special word selection, RotWord, SubWord and the Rcon addition

`timescale 1ns/100ps
`default_nettype none

module aes_key_irregular (
  input  aes_key_pkg::ciph_op_e  op_i,
  input  aes_key_pkg::key_len_e  key_len_i,
  input  aes_key_pkg::key_t      key_i,
  input  logic                   use_rcon_i,
  input  logic [7:0]             rcon_i,
  output aes_key_pkg::key_word_u irregular_o
);

  aes_key_pkg::key_word_u spec_word;
  aes_key_pkg::key_word_u rot_word;
  aes_key_pkg::key_word_u sub_in;
  aes_key_pkg::key_word_u sub_out;

  ////////////////////
  // Word selection
  ////////////////////

  always_comb begin : spec_word_mux
    if (key_len_i == aes_key_pkg::AES_128) begin
      // Inverse 128 recovers the previous last word as w3 ^ w2
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        spec_word.word = key_i[3].word;
      end else begin
        spec_word.word = key_i[3].word ^ key_i[2].word;
      end
    end else begin
      // AES-256 uses the top word forward, the lower half's top inverse
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        spec_word.word = key_i[7].word;
      end else begin
        spec_word.word = key_i[3].word;
      end
    end
  end

  // RotWord goes with Rcon in every remaining round type
  assign rot_word = aes_key_pkg::aes_rot_word(spec_word);
  assign sub_in   = use_rcon_i ? rot_word : spec_word;

  aes_sbox_lut u_sbox (
    .word_i ( sub_in  ),
    .word_o ( sub_out )
  );

  // Rcon only touches the lowest byte
  always_comb begin : rcon_add
    irregular_o = sub_out;
    if (use_rcon_i) begin
      irregular_o.bytes[0] = sub_out.bytes[0] ^ rcon_i;
    end
  end

endmodule

`default_nettype wire

/* aes_rcon_gen.sv */
// Rcon register of the key expansion
// Start values per direction and length, mul2/div2 stepping
// and the per-round decision whether Rcon is consumed

`timescale 1ns/100ps
`default_nettype none

module aes_rcon_gen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  advance_i,
  input  aes_key_pkg::ciph_op_e op_i,
  input  aes_key_pkg::key_len_e key_len_i,
  input  aes_key_pkg::round_t   round_i,
  output logic [7:0]            rcon_o,
  output logic                  use_rcon_o
);

  logic [7:0] rcon_d;
  logic [7:0] rcon_q;
  logic       rcon_we;

  // AES-256 even rounds only run SubWord, all other rounds take Rcon
  assign use_rcon_o = !((key_len_i == aes_key_pkg::AES_256) && !round_i[0]);

  // Next value, either a start value or one step along the sequence
  always_comb begin : rcon_next
    if (clear_i) begin
      if (op_i == aes_key_pkg::CIPH_FWD) begin
        rcon_d = aes_key_pkg::RconFwdInit;
      end else if (key_len_i == aes_key_pkg::AES_128) begin
        rcon_d = aes_key_pkg::RconInv128Init;
      end else begin
        rcon_d = aes_key_pkg::RconInv256Init;
      end
    end else if (op_i == aes_key_pkg::CIPH_FWD) begin
      rcon_d = aes_key_pkg::aes_mul2(rcon_q);
    end else begin
      rcon_d = aes_key_pkg::aes_div2(rcon_q);
    end
  end

  // Step only when the finished round actually used Rcon
  assign rcon_we = clear_i | (advance_i & use_rcon_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin : rcon_reg
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (rcon_we) begin
      rcon_q <= rcon_d;
    end
  end

  assign rcon_o = rcon_q;

  // Clear arrives only between requests, so it never meets an advance
  clear_advance_excl_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(clear_i && advance_i));

endmodule

`default_nettype wire

/* aes_sbox_lut.sv */
// Forward AES S-box as a lookup table
// Substitutes all four bytes of one key word in parallel

`timescale 1ns/100ps
`default_nettype none

module aes_sbox_lut (
  input  aes_key_pkg::key_word_u word_i,
  output aes_key_pkg::key_word_u word_o
);

  // FIPS-197 forward table, indexed by the input byte
  localparam logic [7:0] SBoxFwd [256] = '{
    // 0x00
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    // 0x20
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    // 0x40
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    // 0x60
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    // 0x80
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    // 0xa0
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    // 0xc0
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    // 0xe0
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  ////////////////////
  // Byte lookup
  ////////////////////

  // Each byte goes through its own copy of the table
  always_comb begin : sub_bytes
    for (int i = 0; i < 4; i++) begin
      word_o.bytes[i] = SBoxFwd[word_i.bytes[i]];
    end
  end

endmodule

`default_nettype wire

/* aes_key_pkg.sv */
// Shared types and helpers for the AES round-key update unit
// Direction and key-length enums, key word union and key register type
// GF(2^8) multiply/divide by x, RotWord and the Rcon start values

`default_nettype none

package aes_key_pkg;

  // Direction of the key expansion
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Supported key lengths
  typedef enum logic {
    AES_128 = 1'b0,
    AES_256 = 1'b1
  } key_len_e;

  // One key word, seen whole by the XOR chains or bytewise by SubWord and Rcon
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } key_word_u;

  // Full key register, word 0 holds the lowest-numbered schedule word
  typedef key_word_u [7:0] key_t;

  typedef logic [3:0] round_t;

  // Rcon start values
  localparam logic [7:0] RconFwdInit    = 8'h01;
  localparam logic [7:0] RconInv128Init = 8'h36;
  localparam logic [7:0] RconInv256Init = 8'h40;

  // Multiply by x, reduced by x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] aes_mul2(logic [7:0] in);
    logic [7:0] out;
    out = {in[6:0], 1'b0};
    if (in[7]) begin
      out = out ^ 8'h1b;
    end
    return out;
  endfunction

  // Divide by x, the exact inverse of aes_mul2
  function automatic logic [7:0] aes_div2(logic [7:0] in);
    logic [7:0] out;
    out = {1'b0, in[7:1]};
    // Odd input means the reduction polynomial was folded in
    if (in[0]) begin
      out = out ^ 8'h8d;
    end
    return out;
  endfunction

  // RotWord, byte 1 lands in byte 0 and byte 0 wraps to byte 3
  function automatic key_word_u aes_rot_word(key_word_u in);
    key_word_u out;
    out.word = {in.bytes[0], in.word[31:8]};
    return out;
  endfunction

endpackage

`default_nettype wire
